// ==== dv/tb_clk_gen.sv ====
`default_nettype none
`timescale 1ns/1ns

module tb_clk_gen (
    output logic clk,
    output logic rst_n
);

    localparam int half_period = 50;

    initial begin
        clk   = 1'b0;
        rst_n = 1'b0;
        // reset spans the first 3 clock periods
        #(6 * half_period);
        rst_n = 1'b1;
    end

    always #(half_period) clk = ~clk;

endmodule

`default_nettype wire

// ==== dv/xbar_chk.sv ====
`default_nettype none
`timescale 1ns/1ns

module xbar_chk (
    input logic                            clk,
    input logic                            rst_n,
    input logic                            awvalid   [xbar_pkg::master_num],
    input logic                            awready   [xbar_pkg::master_num],
    input logic [xbar_pkg::master_num-1:0] aw_fire,
    input logic [xbar_pkg::slave_num-1:0]  aw_target [xbar_pkg::master_num],
    input logic [xbar_pkg::slave_num-1:0]  w_target  [xbar_pkg::master_num],
    input logic                            s_wvalid  [xbar_pkg::slave_num]
);

    import xbar_pkg::*;

    for (genvar m = 0; m < master_num; m++) begin : g_master
        a_ready_with_valid: assert property (@(posedge clk) disable iff (!rst_n)
            awready[m] |-> awvalid[m])
            else $error("awready high without awvalid on master %0d", m);
    end

    for (genvar s = 0; s < slave_num; s++) begin : g_slave
        logic [master_num-1:0] aw_hit;
        logic [master_num-1:0] w_owner;
        for (genvar m = 0; m < master_num; m++) begin : g_bit
            assign aw_hit[m]  = aw_fire[m] & aw_target[m][s];
            assign w_owner[m] = w_target[m][s];
        end
        // one address grant per slave
        a_single_aw: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(aw_hit))
            else $error("two address grants at slave %0d", s);
        // data only behind a queued address
        a_w_queued: assert property (@(posedge clk) disable iff (!rst_n)
            s_wvalid[s] |-> |w_owner)
            else $error("write data at slave %0d with no queued address", s);
    end

endmodule

bind axi_wr_xbar xbar_chk u_chk (
    .clk       (clk),
    .rst_n     (rst_n),
    .awvalid   (awvalid),
    .awready   (awready),
    .aw_fire   (aw_fire),
    .aw_target (aw_target),
    .w_target  (w_target),
    .s_wvalid  (s_wvalid)
);

`default_nettype wire

// ==== dv/xbar_tb.sv ====
`default_nettype none
`timescale 1ns/1ns

module xbar_tb;

    import xbar_pkg::*;

    localparam int wait_limit = 200;

    logic                  clk;
    logic                  rst_n;
    logic                  awvalid   [master_num];
    logic                  awready   [master_num];
    logic [id_width-1:0]   awid      [master_num];
    logic [addr_width-1:0] awaddr    [master_num];
    logic [len_width-1:0]  awlen     [master_num];
    logic                  wvalid    [master_num];
    logic                  wready    [master_num];
    logic [data_width-1:0] wdata     [master_num];
    logic [strb_width-1:0] wstrb     [master_num];
    logic                  wlast     [master_num];
    logic                  bvalid    [master_num];
    logic                  bready    [master_num];
    logic [id_width-1:0]   bid       [master_num];
    logic [resp_width-1:0] bresp     [master_num];
    logic                  s_awvalid [slave_num];
    logic                  s_awready [slave_num];
    logic [sid_width-1:0]  s_awid    [slave_num];
    logic [addr_width-1:0] s_awaddr  [slave_num];
    logic [len_width-1:0]  s_awlen   [slave_num];
    logic                  s_wvalid  [slave_num];
    logic                  s_wready  [slave_num];
    logic [data_width-1:0] s_wdata   [slave_num];
    logic [strb_width-1:0] s_wstrb   [slave_num];
    logic                  s_wlast   [slave_num];
    logic                  s_bvalid  [slave_num];
    logic                  s_bready  [slave_num];
    logic [sid_width-1:0]  s_bid     [slave_num];
    logic [resp_width-1:0] s_bresp   [slave_num];

    // expected W target per master in AW order
    int                    w_dest    [master_num][$];
    logic [id_width-1:0]   open_ids  [master_num][$];
    int                    aw_order  [slave_num][$];
    // slave model state
    logic [sid_width-1:0]  slave_ids [slave_num][$];
    logic [sid_width-1:0]  b_ids     [slave_num][$];
    logic [resp_width-1:0] b_resps   [slave_num][$];
    logic                  hold_ready [slave_num];
    string                 test_name;
    int                    error_count;

    tb_clk_gen u_clk_gen (.clk(clk), .rst_n(rst_n));

    axi_wr_xbar u_dut (.*);

    // slave index is address bit 15
    function automatic int route_slave(input logic [addr_width-1:0] addr);
        return addr[addr_width-1] ? 1 : 0;
    endfunction

    function automatic logic [sid_width-1:0] ext_id(input int m, input logic [id_width-1:0] id);
        return {m[0], id};
    endfunction

    function automatic int outstanding();
        int total;
        total = 0;
        for (int k = 0; k < master_num; k++) begin
            total += open_ids[k].size() + w_dest[k].size();
        end
        return total;
    endfunction

    task automatic fail_run(input string why);
        error_count++;
        $display("%s", why);
        $display("Some tests failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_eq(input string what, input logic [31:0] exp, input logic [31:0] act);
        assert (exp == act) else fail_run($sformatf("error %s %s: expected 0x%0h, actual 0x%0h",
            test_name, what, exp, act));
    endtask

    task automatic send_aw(input int m, input logic [id_width-1:0] id,
                           input logic [addr_width-1:0] addr, input int len);
        int n;
        @(negedge clk);
        awvalid[m] = 1'b1;
        awid[m]    = id;
        awaddr[m]  = addr;
        awlen[m]   = len_width'(len);
        n = 0;
        @(posedge clk);
        while (!awready[m]) begin
            n++;
            if (n > wait_limit) fail_run($sformatf("timeout on awready of master %0d", m));
            @(posedge clk);
        end
        @(negedge clk);
        awvalid[m] = 1'b0;
    endtask

    task automatic send_burst(input int m, input int burst, input int beats);
        int n;
        for (int b = 0; b < beats; b++) begin
            @(negedge clk);
            wvalid[m] = 1'b1;
            wdata[m]  = {4'hd, 4'(m), 8'(burst), 16'(b)};
            wstrb[m]  = strb_width'(burst + b + 1);
            wlast[m]  = b == beats - 1;
            n = 0;
            @(posedge clk);
            while (!wready[m]) begin
                n++;
                if (n > wait_limit) fail_run($sformatf("timeout on wready of master %0d", m));
                @(posedge clk);
            end
        end
        @(negedge clk);
        wvalid[m] = 1'b0;
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        while (outstanding() != 0) begin
            n++;
            if (n > wait_limit) fail_run("timeout waiting for write responses");
            @(negedge clk);
        end
    endtask

    // slave and master ready models
    always @(negedge clk) begin
        for (int k = 0; k < slave_num; k++) begin
            s_awready[k] = !hold_ready[k] && ($urandom % 3 != 0);
            s_wready[k]  = !hold_ready[k] && ($urandom % 3 != 0);
            s_bvalid[k]  = b_ids[k].size() != 0;
            s_bid[k]     = s_bvalid[k] ? b_ids[k][0] : '0;
            s_bresp[k]   = s_bvalid[k] ? b_resps[k][0] : '0;
        end
        for (int k = 0; k < master_num; k++) begin
            bready[k] = $urandom % 4 != 0;
        end
    end

    // compares every handshake on both sides
    always @(posedge clk) begin
        int s;
        int m;
        int hit;
        if (rst_n) begin
            for (int k = 0; k < master_num; k++) begin
                if (wvalid[k] && wready[k]) begin
                    if (w_dest[k].size() == 0) begin
                        fail_run("write beat accepted with no address outstanding");
                    end else begin
                        s = w_dest[k][0];
                        check_eq("w reaches slave", 1, s_wvalid[s] && s_wready[s]);
                        check_eq("s_wdata", wdata[k], s_wdata[s]);
                        check_eq("s_wstrb", wstrb[k], s_wstrb[s]);
                        check_eq("s_wlast", wlast[k], s_wlast[s]);
                        if (wlast[k]) w_dest[k].pop_front();
                    end
                end
                if (awvalid[k] && awready[k]) begin
                    s = route_slave(awaddr[k]);
                    check_eq("aw reaches slave", 1, s_awvalid[s] && s_awready[s]);
                    check_eq("s_awid", ext_id(k, awid[k]), s_awid[s]);
                    check_eq("s_awaddr", awaddr[k], s_awaddr[s]);
                    check_eq("s_awlen", awlen[k], s_awlen[s]);
                    w_dest[k].push_back(s);
                    open_ids[k].push_back(awid[k]);
                end
                if (bvalid[k] && bready[k]) begin
                    hit = -1;
                    for (int i = 0; i < open_ids[k].size(); i++) begin
                        if (hit < 0 && open_ids[k][i] == bid[k]) hit = i;
                    end
                    check_eq("bid issued", 1, hit >= 0);
                    open_ids[k].delete(hit);
                end
            end
            for (int k = 0; k < slave_num; k++) begin
                if (s_awvalid[k] && s_awready[k]) begin
                    m = int'(s_awid[k][sid_width-1]);
                    check_eq("aw source", 1, awvalid[m] && awready[m]);
                    aw_order[k].push_back(m);
                    slave_ids[k].push_back(s_awid[k]);
                end
                if (s_wvalid[k] && s_wready[k]) begin
                    m = int'(s_wdata[k][27:24]);
                    check_eq("w source", 1, wvalid[m] && wready[m]);
                    if (s_wlast[k]) begin
                        hit = -1;
                        for (int i = 0; i < slave_ids[k].size(); i++) begin
                            if (hit < 0 && slave_ids[k][i][sid_width-1] == m[0]) hit = i;
                        end
                        check_eq("burst has address", 1, hit >= 0);
                        b_ids[k].push_back(slave_ids[k][hit]);
                        b_resps[k].push_back(resp_width'($urandom % 4));
                        slave_ids[k].delete(hit);
                    end
                end
                if (s_bvalid[k] && s_bready[k]) begin
                    m = int'(s_bid[k][sid_width-1]);
                    check_eq("b reaches master", 1, bvalid[m] && bready[m]);
                    check_eq("bid", s_bid[k][id_width-1:0], bid[m]);
                    check_eq("bresp", b_resps[k][0], bresp[m]);
                    b_ids[k].pop_front();
                    b_resps[k].pop_front();
                end
            end
        end
    end

    initial begin
        int n;
        void'($urandom(78));
        error_count = 0;
        test_name   = "reset";
        for (int k = 0; k < master_num; k++) begin
            awvalid[k] = 1'b0;
            awid[k]    = '0;
            awaddr[k]  = '0;
            awlen[k]   = '0;
            wvalid[k]  = 1'b0;
            wdata[k]   = '0;
            wstrb[k]   = '0;
            wlast[k]   = 1'b0;
            bready[k]  = 1'b0;
        end
        for (int k = 0; k < slave_num; k++) begin
            s_awready[k]  = 1'b0;
            s_wready[k]   = 1'b0;
            s_bvalid[k]   = 1'b0;
            s_bid[k]      = '0;
            s_bresp[k]    = '0;
            hold_ready[k] = 1'b0;
        end
        n = 0;
        while (rst_n !== 1'b1) begin
            n++;
            if (n > wait_limit) fail_run("reset was never released");
            @(posedge clk);
        end

        test_name = "idle";
        @(negedge clk);
        wvalid[0] = 1'b1;
        wlast[0]  = 1'b1;
        repeat (4) begin
            @(posedge clk);
            for (int k = 0; k < slave_num; k++) begin
                check_eq("s_awvalid", 0, s_awvalid[k]);
                check_eq("s_wvalid", 0, s_wvalid[k]);
            end
            for (int k = 0; k < master_num; k++) begin
                check_eq("bvalid", 0, bvalid[k]);
            end
            check_eq("wready", 0, wready[0]);
        end
        @(negedge clk);
        wvalid[0] = 1'b0;

        // pointers are still at reset here
        test_name = "same_slave_race";
        fork
            send_aw(0, 4'h3, 16'h0100, 0);
            send_aw(1, 4'h5, 16'h0200, 0);
        join
        check_eq("grants at slave 0", 2, aw_order[0].size());
        check_eq("first grant", 0, aw_order[0][0]);
        check_eq("second grant", 1, aw_order[0][1]);
        send_burst(0, 0, 1);
        send_burst(1, 0, 1);
        wait_idle();

        test_name = "single_writes";
        for (int m = 0; m < master_num; m++) begin
            for (int s = 0; s < slave_num; s++) begin
                send_aw(m, 4'(4 * m + s + 6), 16'(32'h8000 * s + 32'h10), 0);
                send_burst(m, s, 1);
                wait_idle();
            end
        end

        test_name = "order_two_slaves";
        send_aw(1, 4'ha, 16'h0400, 1);
        send_aw(1, 4'hb, 16'hc000, 2);
        send_burst(1, 1, 2);
        send_burst(1, 2, 3);
        wait_idle();

        test_name = "backpressure";
        @(posedge clk);
        hold_ready[0] = 1'b1;
        fork
            send_aw(0, 4'h9, 16'h0040, 0);
            begin
                repeat (4) begin
                    @(posedge clk);
                    check_eq("awready held", 0, awready[0]);
                    check_eq("s_awvalid held", 1, s_awvalid[0]);
                    check_eq("s_awaddr held", awaddr[0], s_awaddr[0]);
                    check_eq("s_awid held", ext_id(0, awid[0]), s_awid[0]);
                    check_eq("s_awlen held", awlen[0], s_awlen[0]);
                end
                hold_ready[0] = 1'b0;
            end
        join
        send_burst(0, 3, 1);
        wait_idle();

        test_name = "queue_full";
        for (int k = 0; k < w_buf_depth; k++) begin
            send_aw(0, 4'(k), 16'h8800, 0);
        end
        fork
            send_aw(0, 4'h4, 16'h8900, 0);
            begin
                repeat (4) begin
                    @(posedge clk);
                    check_eq("awready while full", 0, awready[0]);
                    check_eq("s_awvalid while full", 0, s_awvalid[1]);
                end
                send_burst(0, 4, 1);
            end
        join
        for (int k = 0; k < w_buf_depth; k++) begin
            send_burst(0, 5 + k, 1);
        end
        wait_idle();

        if (error_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the AXI write crossbar testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module xbar_tb -f vlog.f -o xbar_sim \
    && ./obj_dir/xbar_sim 2>&1 | tee sim.log
grep -q "All tests passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// ==== source/axi_wr_xbar.sv ====
`default_nettype none
`timescale 1ns/1ns

module axi_wr_xbar (
    input  logic                            clk,
    input  logic                            rst_n,

    // masters
    input  logic                            awvalid   [xbar_pkg::master_num],
    output logic                            awready   [xbar_pkg::master_num],
    input  logic [xbar_pkg::id_width-1:0]   awid      [xbar_pkg::master_num],
    input  logic [xbar_pkg::addr_width-1:0] awaddr    [xbar_pkg::master_num],
    input  logic [xbar_pkg::len_width-1:0]  awlen     [xbar_pkg::master_num],
    input  logic                            wvalid    [xbar_pkg::master_num],
    output logic                            wready    [xbar_pkg::master_num],
    input  logic [xbar_pkg::data_width-1:0] wdata     [xbar_pkg::master_num],
    input  logic [xbar_pkg::strb_width-1:0] wstrb     [xbar_pkg::master_num],
    input  logic                            wlast     [xbar_pkg::master_num],
    output logic                            bvalid    [xbar_pkg::master_num],
    input  logic                            bready    [xbar_pkg::master_num],
    output logic [xbar_pkg::id_width-1:0]   bid       [xbar_pkg::master_num],
    output logic [xbar_pkg::resp_width-1:0] bresp     [xbar_pkg::master_num],

    // slaves
    output logic                            s_awvalid [xbar_pkg::slave_num],
    input  logic                            s_awready [xbar_pkg::slave_num],
    output logic [xbar_pkg::sid_width-1:0]  s_awid    [xbar_pkg::slave_num],
    output logic [xbar_pkg::addr_width-1:0] s_awaddr  [xbar_pkg::slave_num],
    output logic [xbar_pkg::len_width-1:0]  s_awlen   [xbar_pkg::slave_num],
    output logic                            s_wvalid  [xbar_pkg::slave_num],
    input  logic                            s_wready  [xbar_pkg::slave_num],
    output logic [xbar_pkg::data_width-1:0] s_wdata   [xbar_pkg::slave_num],
    output logic [xbar_pkg::strb_width-1:0] s_wstrb   [xbar_pkg::slave_num],
    output logic                            s_wlast   [xbar_pkg::slave_num],
    input  logic                            s_bvalid  [xbar_pkg::slave_num],
    output logic                            s_bready  [xbar_pkg::slave_num],
    input  logic [xbar_pkg::sid_width-1:0]  s_bid     [xbar_pkg::slave_num],
    input  logic [xbar_pkg::resp_width-1:0] s_bresp   [xbar_pkg::slave_num]
);

    import xbar_pkg::*;

    aw_payload_t                aw_in    [master_num];
    aw_payload_t                aw_out   [slave_num];
    w_payload_t                 w_in     [master_num];
    w_payload_t                 w_out    [slave_num];
    b_payload_t                 b_in     [slave_num];
    b_payload_t                 b_out    [master_num];
    logic [slave_num-1:0]       aw_target [master_num];
    logic [slave_num-1:0]       w_target  [master_num];
    logic [master_num-1:0]      b_target  [slave_num];
    logic [master_num-1:0]      aw_fire;
    logic [master_num-1:0]      w_fire;
    logic [master_num-1:0]      w_last_fire;
    logic [slave_num-1:0]       b_fire;
    logic [extra_id_width-1:0]  aw_ptr;
    logic [extra_id_width-1:0]  w_ptr;
    logic [slave_idx_width-1:0] b_ptr;

    for (genvar m = 0; m < master_num; m++) begin : g_master
        assign aw_fire[m]     = awvalid[m] & awready[m];
        assign w_fire[m]      = wvalid[m] & wready[m];
        assign w_last_fire[m] = w_fire[m] & wlast[m];

        // master index goes in front of the id
        assign aw_in[m] = '{id: {extra_id_width'(m), awid[m]}, addr: awaddr[m], len: awlen[m]};
        assign w_in[m]  = '{data: wdata[m], strb: wstrb[m], last: wlast[m]};

        assign bid[m]   = b_out[m].id;
        assign bresp[m] = b_out[m].resp;

        write_order_queue u_order_q (
            .clk         (clk),
            .rst_n       (rst_n),
            .awvalid     (awvalid[m]),
            .awaddr      (awaddr[m]),
            .aw_fire     (aw_fire[m]),
            .w_last_fire (w_last_fire[m]),
            .aw_target   (aw_target[m]),
            .w_target    (w_target[m])
        );
    end

    for (genvar s = 0; s < slave_num; s++) begin : g_slave
        assign b_fire[s] = s_bvalid[s] & s_bready[s];

        // top id bits name the master, the rest is the original id
        assign b_in[s]     = '{id: s_bid[s][id_width-1:0], resp: s_bresp[s]};
        assign b_target[s] = master_num'(1) << s_bid[s][sid_width-1 -: extra_id_width];

        assign s_awid[s]   = aw_out[s].id;
        assign s_awaddr[s] = aw_out[s].addr;
        assign s_awlen[s]  = aw_out[s].len;
        assign s_wdata[s]  = w_out[s].data;
        assign s_wstrb[s]  = w_out[s].strb;
        assign s_wlast[s]  = w_out[s].last;
    end

    chan_switch #(.payload_t(aw_payload_t), .senders(master_num), .receivers(slave_num)) u_aw_sw (
        .valid      (awvalid),
        .payload    (aw_in),
        .target     (aw_target),
        .ready      (awready),
        .rx_valid   (s_awvalid),
        .rx_payload (aw_out),
        .rx_ready   (s_awready),
        .ptr        (aw_ptr)
    );

    chan_switch #(.payload_t(w_payload_t), .senders(master_num), .receivers(slave_num)) u_w_sw (
        .valid      (wvalid),
        .payload    (w_in),
        .target     (w_target),
        .ready      (wready),
        .rx_valid   (s_wvalid),
        .rx_payload (w_out),
        .rx_ready   (s_wready),
        .ptr        (w_ptr)
    );

    chan_switch #(.payload_t(b_payload_t), .senders(slave_num), .receivers(master_num)) u_b_sw (
        .valid      (s_bvalid),
        .payload    (b_in),
        .target     (b_target),
        .ready      (s_bready),
        .rx_valid   (bvalid),
        .rx_payload (b_out),
        .rx_ready   (bready),
        .ptr        (b_ptr)
    );

    rr_prio_reg #(.n(master_num)) aw_prio (.clk(clk), .rst_n(rst_n), .fire(aw_fire), .ptr(aw_ptr));
    rr_prio_reg #(.n(master_num)) w_prio (.clk(clk), .rst_n(rst_n), .fire(w_fire), .ptr(w_ptr));
    rr_prio_reg #(.n(slave_num)) b_prio (.clk(clk), .rst_n(rst_n), .fire(b_fire), .ptr(b_ptr));

endmodule

`default_nettype wire

// ==== source/chan_switch.sv ====
`default_nettype none
`timescale 1ns/1ns

module chan_switch #(
    parameter type payload_t = xbar_pkg::aw_payload_t,
    parameter int  senders   = xbar_pkg::master_num,
    parameter int  receivers = xbar_pkg::slave_num
) (
    input  logic                        valid      [senders],
    input  payload_t                    payload    [senders],
    input  logic [receivers-1:0]        target     [senders],
    output logic                        ready      [senders],
    output logic                        rx_valid   [receivers],
    output payload_t                    rx_payload [receivers],
    input  logic                        rx_ready   [receivers],
    input  logic [$clog2(senders)-1:0]  ptr
);

    // grant[r][s] set when sender s owns receiver r this cycle
    logic [senders-1:0] grant [receivers];

    // first requester at or above ptr, wrapping
    always_comb begin
        int   idx;
        logic found;
        for (int r = 0; r < receivers; r++) begin
            grant[r] = '0;
            found    = 1'b0;
            for (int k = 0; k < senders; k++) begin
                idx = (int'(ptr) + k) % senders;
                if (!found && valid[idx] && target[idx][r]) begin
                    grant[r][idx] = 1'b1;
                    found         = 1'b1;
                end
            end
        end
    end

    // receiver side mux
    always_comb begin
        for (int r = 0; r < receivers; r++) begin
            rx_valid[r]   = 1'b0;
            rx_payload[r] = '0;
            for (int s = 0; s < senders; s++) begin
                if (grant[r][s]) begin
                    rx_valid[r]   = 1'b1;
                    rx_payload[r] = payload[s];
                end
            end
        end
    end

    // ready only goes back to the granted sender
    always_comb begin
        for (int s = 0; s < senders; s++) begin
            ready[s] = 1'b0;
            for (int r = 0; r < receivers; r++) begin
                if (grant[r][s] && rx_ready[r]) begin
                    ready[s] = 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/rr_prio_reg.sv ====
`default_nettype none
`timescale 1ns/1ns

module rr_prio_reg #(
    parameter int n = xbar_pkg::master_num
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [n-1:0]          fire,
    output logic [$clog2(n)-1:0]  ptr
);

    logic [$clog2(n)-1:0] ptr_nxt;

    // lowest firing sender decides, so scan from the top down
    always_comb begin
        ptr_nxt = ptr;
        for (int k = n - 1; k >= 0; k--) begin
            if (fire[k]) begin
                if (k == n - 1) begin
                    ptr_nxt = '0;
                end else begin
                    ptr_nxt = ($clog2(n))'(k + 1);
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ptr <= '0;
        end else if (|fire) begin
            ptr <= ptr_nxt;
        end
    end

endmodule

`default_nettype wire

// ==== source/write_order_queue.sv ====
`default_nettype none
`timescale 1ns/1ns

module write_order_queue (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            awvalid,
    input  logic [xbar_pkg::addr_width-1:0] awaddr,
    input  logic                            aw_fire,
    input  logic                            w_last_fire,
    output logic [xbar_pkg::slave_num-1:0]  aw_target,
    output logic [xbar_pkg::slave_num-1:0]  w_target
);

    import xbar_pkg::*;

    logic [slave_num-1:0]   mem [w_buf_depth];
    logic [w_ptr_width-1:0] wr_ptr;
    logic [w_ptr_width-1:0] rd_ptr;
    logic [w_cnt_width-1:0] count;
    logic                   full;
    logic                   empty;
    logic                   push;
    logic                   pop;

    assign full  = count == w_cnt_width'(w_buf_depth);
    assign empty = count == '0;
    assign push  = aw_fire & ~full;
    assign pop   = w_last_fire & ~empty;

    // no request toward any slave while the order queue cannot take it
    assign aw_target = (awvalid && !full) ? decode_slave(awaddr) : '0;

    // head entry steers this master's write beats
    assign w_target = empty ? '0 : mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= decode_slave(awaddr);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == w_ptr_width'(w_buf_depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == w_ptr_width'(w_buf_depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== source/xbar_pkg.sv ====
`default_nettype none

package xbar_pkg;

    localparam int master_num      = 2;
    localparam int slave_num       = 2;
    localparam int addr_width      = 16;
    localparam int data_width      = 32;
    localparam int strb_width      = data_width / 8;
    localparam int id_width        = 4;
    localparam int extra_id_width  = 1;
    localparam int sid_width       = id_width + extra_id_width;
    localparam int len_width       = 8;
    localparam int resp_width      = 2;

    // write-order queue geometry
    localparam int w_buf_depth     = 4;
    localparam int w_ptr_width     = $clog2(w_buf_depth);
    localparam int w_cnt_width     = $clog2(w_buf_depth + 1);

    // slave index lives in the top address bits, so bit 15 picks slave 1
    localparam int slave_idx_width = $clog2(slave_num);
    localparam int slave_idx_lsb   = addr_width - slave_idx_width;

    typedef struct packed {
        logic [sid_width-1:0]  id;
        logic [addr_width-1:0] addr;
        logic [len_width-1:0]  len;
    } aw_payload_t;

    typedef struct packed {
        logic [data_width-1:0] data;
        logic [strb_width-1:0] strb;
        logic                  last;
    } w_payload_t;

    typedef struct packed {
        logic [id_width-1:0]   id;
        logic [resp_width-1:0] resp;
    } b_payload_t;

    // one-hot slave select from the address map
    function automatic logic [slave_num-1:0] decode_slave(input logic [addr_width-1:0] addr);
        logic [slave_num-1:0] sel;
        sel = '0;
        sel[addr[slave_idx_lsb +: slave_idx_width]] = 1'b1;
        return sel;
    endfunction

endpackage

`default_nettype wire

// ==== vlog.f ====
source/xbar_pkg.sv
source/rr_prio_reg.sv
source/write_order_queue.sv
source/chan_switch.sv
source/axi_wr_xbar.sv
dv/tb_clk_gen.sv
dv/xbar_chk.sv
dv/xbar_tb.sv
